/* decodeStage.f */
+incdir+hw
hw/idPkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/decodeStage.sv
verif/decodeStage_checker.sv
verif/decodeStage_tb.sv

/* hw/decodeStage.sv */
`include "idConsts_consts.svh"

module decodeStage (
    input  logic                clk,
    input  logic                rst,
    input  logic [`DATA_W-1:0]  instr,
    input  logic [`REG_AW-1:0]  writeBackReg,
    input  logic [`DATA_W-1:0]  writeBackData,
    output idPkg::regRead_t     rd,
    output idPkg::decodeCtrl_t  ctrl,
    output logic [`DATA_W-1:0]  immNum,
    output logic [`DATA_W-1:0]  readData1,
    output logic [`DATA_W-1:0]  readData2
);

    instrDecoder u_decoder (
        .instr  (instr),
        .rd     (rd),     // Also drives the register file
        .ctrl   (ctrl),
        .immNum (immNum)
    );

    regFile u_regFile (
        .clk           (clk),
        .rst           (rst),
        .rd            (rd),
        .writeBackReg  (writeBackReg),
        .writeBackData (writeBackData),
        .readData1     (readData1),
        .readData2     (readData2)
    );

endmodule

/* hw/idConsts_consts.svh */
`ifndef ID_CONSTS_CONSTS_SVH
`define ID_CONSTS_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////

`define DATA_W 16 // Data path and immediate
`define REG_AW 4  // Register address

////////////////////////////////////////////////////////////////////////////
// Special register numbers
////////////////////////////////////////////////////////////////////////////

`define REG_SP   4'd8
`define REG_T    4'd9
`define REG_IH   4'd10
`define REG_ZERO 4'd15 // Reads as zero and means no write

////////////////////////////////////////////////////////////////////////////
// Instruction fields
////////////////////////////////////////////////////////////////////////////

`define OPC 15:11 // Major opcode
`define RX  10:8
`define RY  7:5
`define RZ  4:2
`define FN2 1:0   // Sub-function for shifts and ADDU/SUBU
`define FN5 4:0   // Sub-function for the 11101 group

`endif

/* hw/idPkg.sv */
`include "idConsts_consts.svh"

package idPkg;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluNeg = 4'd4,
        aluNot = 4'd5,
        aluSll = 4'd6,
        aluSra = 4'd8,
        aluSlt = 4'd9,
        aluCmp = 4'd10,
        aluPc  = 4'd11
    } aluOp_e;

    typedef enum logic [1:0] {
        srcReg  = 2'd0,
        srcImm  = 2'd1,
        srcNone = 2'd2
    } srcBSel_e;

    typedef enum logic [1:0] {
        memRead  = 2'd1,
        memWrite = 2'd2,
        memNone  = 2'd3
    } memOp_e;

    typedef enum logic [1:0] {
        brAlways  = 2'd0, // B
        brReg     = 2'd1, // JR
        brZero    = 2'd2,
        brNonZero = 2'd3
    } branchCond_e;

    typedef struct packed {
        aluOp_e              aluOp;
        srcBSel_e            srcBSel;
        memOp_e              memOp;
        logic                flowChange;
        branchCond_e         branchCond;
        logic                wbFromMem;  // Loads only
        logic [`REG_AW-1:0]  writeReg;
    } decodeCtrl_t;

    typedef struct packed {
        logic [`REG_AW-1:0] readReg1;
        logic [`REG_AW-1:0] readReg2;
    } regRead_t;

    // Bundle for every unknown encoding
    localparam decodeCtrl_t nopCtrl = '{
        aluOp:      aluAdd,
        srcBSel:    srcNone,
        memOp:      memNone,
        flowChange: 1'b0,
        branchCond: brNonZero,
        wbFromMem:  1'b0,
        writeReg:   `REG_ZERO
    };

endpackage

/* hw/instrDecoder.sv */
`include "idConsts_consts.svh"

module instrDecoder (
    input  logic [`DATA_W-1:0] instr,
    output idPkg::regRead_t    rd,
    output idPkg::decodeCtrl_t ctrl,
    output logic [`DATA_W-1:0] immNum
);
    import idPkg::*;

    logic [`REG_AW-1:0] rx;
    logic [`REG_AW-1:0] ry;
    logic [`REG_AW-1:0] rz;
    logic [`DATA_W-1:0] shiftAmt;

    assign rx = {1'b0, instr[`RX]};
    assign ry = {1'b0, instr[`RY]};
    assign rz = {1'b0, instr[`RZ]};
    assign shiftAmt = (instr[`RZ] == 3'd0) ? `DATA_W'(8) : `DATA_W'(instr[`RZ]); // 0 means 8

    always_comb begin
        // Start from NOP and let each encoding override its fields
        rd.readReg1 = `REG_ZERO;
        rd.readReg2 = `REG_ZERO;
        ctrl = nopCtrl;
        immNum = '0;

        case (instr[`OPC])
            ////////////////////////////////////////////////////////////////////////////
            // Branches
            ////////////////////////////////////////////////////////////////////////////
            5'b00010: begin // B
                ctrl.flowChange = 1'b1;
                ctrl.branchCond = brAlways;
                immNum = {{5{instr[10]}}, instr[10:0]};
            end
            5'b00100, 5'b00101: begin // BEQZ, BNEZ
                rd.readReg1 = rx;
                ctrl.aluOp = aluSub;
                ctrl.flowChange = 1'b1;
                ctrl.branchCond = instr[11] ? brNonZero : brZero;
                immNum = {{8{instr[7]}}, instr[7:0]};
            end

            ////////////////////////////////////////////////////////////////////////////
            // Immediate arithmetic
            ////////////////////////////////////////////////////////////////////////////
            5'b00110: begin // SLL, SRA
                if (instr[`FN2] == 2'b00 || instr[`FN2] == 2'b11) begin
                    rd.readReg1 = ry;
                    ctrl.aluOp = instr[0] ? aluSra : aluSll;
                    ctrl.srcBSel = srcImm;
                    ctrl.writeReg = rx;
                    immNum = shiftAmt;
                end
            end
            5'b01000: begin // ADDIU3
                rd.readReg1 = rx;
                ctrl.srcBSel = srcImm;
                ctrl.writeReg = ry;
                immNum = {{12{instr[3]}}, instr[3:0]};
            end
            5'b01001: begin // ADDIU
                rd.readReg1 = rx;
                ctrl.srcBSel = srcImm;
                ctrl.writeReg = rx;
                immNum = {{8{instr[7]}}, instr[7:0]};
            end
            5'b01011: begin // SLTI
                rd.readReg1 = rx;
                ctrl.aluOp = aluSlt;
                ctrl.srcBSel = srcImm;
                ctrl.writeReg = `REG_T;
                immNum = {8'h00, instr[7:0]};
            end
            5'b01100: begin
                case (instr[`RX])
                    3'b011: begin // ADDSP
                        rd.readReg1 = `REG_SP;
                        ctrl.srcBSel = srcImm;
                        ctrl.writeReg = `REG_SP;
                        immNum = {{8{instr[7]}}, instr[7:0]};
                    end
                    3'b000: begin // BTEQZ
                        rd.readReg1 = `REG_T;
                        ctrl.aluOp = aluSub;
                        ctrl.flowChange = 1'b1;
                        ctrl.branchCond = brZero;
                        immNum = {{8{instr[7]}}, instr[7:0]};
                    end
                    3'b100: begin // MTSP
                        rd.readReg1 = ry;
                        ctrl.writeReg = `REG_SP;
                    end
                    default: ;
                endcase
            end
            5'b01101: begin // LI with zero extension
                ctrl.srcBSel = srcImm;
                ctrl.writeReg = rx;
                immNum = {8'h00, instr[7:0]};
            end
            5'b01111: begin // MOVE
                rd.readReg1 = ry;
                ctrl.srcBSel = srcReg;
                ctrl.writeReg = rx;
            end

            ////////////////////////////////////////////////////////////////////////////
            // Loads and stores
            ////////////////////////////////////////////////////////////////////////////
            5'b10010: begin // LW_SP
                rd.readReg1 = `REG_SP;
                ctrl.srcBSel = srcImm;
                ctrl.memOp = memRead;
                ctrl.wbFromMem = 1'b1;
                ctrl.writeReg = rx;
                immNum = {{8{instr[7]}}, instr[7:0]};
            end
            5'b10011: begin // LW
                rd.readReg1 = rx;
                ctrl.srcBSel = srcImm;
                ctrl.memOp = memRead;
                ctrl.wbFromMem = 1'b1;
                ctrl.writeReg = ry;
                immNum = {{11{instr[4]}}, instr[4:0]};
            end
            5'b11010: begin // SW_SP
                rd.readReg1 = `REG_SP;
                rd.readReg2 = rx; // Store data
                ctrl.memOp = memWrite;
                immNum = {{8{instr[7]}}, instr[7:0]};
            end
            5'b11011: begin // SW
                rd.readReg1 = rx;
                rd.readReg2 = ry;
                ctrl.srcBSel = srcImm;
                ctrl.memOp = memWrite;
                immNum = {{11{instr[4]}}, instr[4:0]};
            end

            ////////////////////////////////////////////////////////////////////////////
            // Register-register
            ////////////////////////////////////////////////////////////////////////////
            5'b11100: begin // ADDU, SUBU
                if (instr[0]) begin
                    rd.readReg1 = rx;
                    rd.readReg2 = ry;
                    ctrl.aluOp = instr[1] ? aluSub : aluAdd;
                    ctrl.srcBSel = srcReg;
                    ctrl.writeReg = rz;
                end
            end
            5'b11101: begin
                case (instr[`FN5])
                    5'b00000: begin
                        if (instr[`RY] == 3'b000) begin // JR
                            rd.readReg1 = rx;
                            ctrl.flowChange = 1'b1;
                            ctrl.branchCond = brReg;
                        end else if (instr[`RY] == 3'b010) begin // MFPC
                            ctrl.aluOp = aluPc;
                            ctrl.writeReg = rx;
                        end
                    end
                    5'b00010, 5'b01010: begin // SLT, CMP
                        rd.readReg1 = rx;
                        rd.readReg2 = ry;
                        ctrl.aluOp = instr[3] ? aluCmp : aluSlt;
                        ctrl.srcBSel = srcReg;
                        ctrl.writeReg = `REG_T;
                    end
                    5'b01011: begin // NEG
                        rd.readReg1 = ry;
                        ctrl.aluOp = aluNeg;
                        ctrl.srcBSel = srcReg;
                        ctrl.writeReg = rx;
                    end
                    5'b01100, 5'b01101: begin // AND, OR
                        rd.readReg1 = rx;
                        rd.readReg2 = ry;
                        ctrl.aluOp = instr[0] ? aluOr : aluAnd;
                        ctrl.srcBSel = srcReg;
                        ctrl.writeReg = rx;
                    end
                    5'b01111: begin // NOT
                        rd.readReg1 = ry;
                        ctrl.aluOp = aluNot;
                        ctrl.writeReg = rx;
                    end
                    default: ;
                endcase
            end
            5'b11110: begin
                if (instr[7:0] == 8'h00) begin // MFIH
                    rd.readReg1 = `REG_IH;
                    ctrl.writeReg = rx;
                end else if (instr[7:0] == 8'h01) begin // MTIH
                    rd.readReg1 = rx;
                    ctrl.writeReg = `REG_IH;
                end
            end
            default: ; // NOP and unknown opcodes
        endcase
    end

endmodule

/* hw/regFile.sv */
`include "idConsts_consts.svh"

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  idPkg::regRead_t     rd,
    input  logic [`REG_AW-1:0]  writeBackReg,
    input  logic [`DATA_W-1:0]  writeBackData,
    output logic [`DATA_W-1:0]  readData1,
    output logic [`DATA_W-1:0]  readData2
);

    logic [`DATA_W-1:0] regs [0:14]; // Entry 15 not stored
    logic               wrEn;

    assign wrEn = (writeBackReg != `REG_ZERO);

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[writeBackReg] <= writeBackData;
        end
    end

    // Zero register first, then write-back bypass, then storage
    function automatic logic [`DATA_W-1:0] readPort(input logic [`REG_AW-1:0] addr);
        logic [`DATA_W-1:0] value;
        if (addr == `REG_ZERO) begin
            value = '0;
        end else if (addr == writeBackReg) begin
            value = writeBackData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        readData1 = readPort(rd.readReg1);
        readData2 = readPort(rd.readReg2);
    end

endmodule

/* runSim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module decodeStage_tb \
        -f decodeStage.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

# Raise the error limit so assertion failures do not end the run early
if ! simOut=$(./obj_dir/VdecodeStage_tb +verilator+error+limit+1000); then
    echo "$simOut"
    echo "Simulation exited with an error status"
    exit 1
fi
echo "$simOut"

if printf '%s\n' "$simOut" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

/* verif/decodeStage_checker.sv */
`include "idConsts_consts.svh"

module decodeStage_checker (
    input logic                clk,
    input logic                rst,
    input idPkg::regRead_t     rd,
    input logic [`REG_AW-1:0]  writeBackReg,
    input logic [`DATA_W-1:0]  writeBackData,
    input logic [`DATA_W-1:0]  readData1,
    input logic [`DATA_W-1:0]  readData2
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`DATA_W-1:0] shadow [0:15];
    logic               noWriteYet;    // No write since the last reset
    int unsigned        failReset = 0;
    int unsigned        failStored = 0;
    int unsigned        failZero = 0;
    int unsigned        failForward = 0;
    int unsigned        errCount;

    assign errCount = failReset + failStored + failZero + failForward;

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 16; i++) begin
                shadow[i] <= '0;
            end
            noWriteYet <= 1'b1;
        end else if (writeBackReg != `REG_ZERO) begin
            shadow[writeBackReg] <= writeBackData;
            noWriteYet <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read port assertions
    ////////////////////////////////////////////////////////////////////////////

    aResetClear: assert property (@(posedge clk)
        rst && noWriteYet && writeBackReg == `REG_ZERO |-> readData1 == '0 && readData2 == '0)
        else begin
            failReset++;
            $error("FAILED at %0t: read data not zero after reset", $time);
        end

    aStored: assert property (@(posedge clk) rst |->
        (rd.readReg1 == `REG_ZERO || rd.readReg1 == writeBackReg
            || readData1 == shadow[rd.readReg1])
        && (rd.readReg2 == `REG_ZERO || rd.readReg2 == writeBackReg
            || readData2 == shadow[rd.readReg2]))
        else begin
            failStored++;
            $error("FAILED at %0t: read data differs from shadow model", $time);
        end

    aZero: assert property (@(posedge clk)
        (rd.readReg1 != `REG_ZERO || readData1 == '0)
        && (rd.readReg2 != `REG_ZERO || readData2 == '0))
        else begin
            failZero++;
            $error("FAILED at %0t: register 15 read nonzero", $time);
        end

    // Same-cycle bypass of the write-back value
    aForward: assert property (@(posedge clk) rst && writeBackReg != `REG_ZERO |->
        (rd.readReg1 != writeBackReg || readData1 == writeBackData)
        && (rd.readReg2 != writeBackReg || readData2 == writeBackData))
        else begin
            failForward++;
            $error("FAILED at %0t: write-back value not forwarded", $time);
        end

endmodule

bind decodeStage decodeStage_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .rd            (rd),
    .writeBackReg  (writeBackReg),
    .writeBackData (writeBackData),
    .readData1     (readData1),
    .readData2     (readData2)
);

/* verif/decodeStage_tb.sv */
`include "idConsts_consts.svh"

module decodeStage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import idPkg::*;

    localparam int resetCycles = 3;
    localparam int randomCycles = 400;
    localparam int cycleLimit = 1000; // More than twice the length of the tests

    logic               clk;
    logic               rst;
    logic [`DATA_W-1:0] instr;
    logic [`REG_AW-1:0] writeBackReg;
    logic [`DATA_W-1:0] writeBackData;
    regRead_t           rd;
    decodeCtrl_t        ctrl;
    logic [`DATA_W-1:0] immNum;
    logic [`DATA_W-1:0] readData1;
    logic [`DATA_W-1:0] readData2;

    int unsigned cycleCount = 0;
    int unsigned decodeErrors = 0;
    logic [31:0] rngState;

    decodeStage u_decodeStage (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .writeBackReg  (writeBackReg),
        .writeBackData (writeBackData),
        .rd            (rd),
        .ctrl          (ctrl),
        .immNum        (immNum),
        .readData1     (readData1),
        .readData2     (readData2)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic decodeCtrl_t ctrlOf(input aluOp_e alu, input srcBSel_e srcB,
                                           input memOp_e mem, input int flow,
                                           input branchCond_e br, input int fromMem,
                                           input int wreg);
        decodeCtrl_t c;
        c.aluOp = alu;
        c.srcBSel = srcB;
        c.memOp = mem;
        c.flowChange = (flow != 0);
        c.branchCond = br;
        c.wbFromMem = (fromMem != 0);
        c.writeReg = 4'(wreg);
        return c;
    endfunction

    // Major opcodes the decoder handles
    function automatic bit isDecodedOpcode(input logic [4:0] op);
        case (op)
            5'b00010, 5'b00100, 5'b00101, 5'b00110, 5'b01000, 5'b01001, 5'b01011,
            5'b01100, 5'b01101, 5'b01111, 5'b10010, 5'b10011, 5'b11010, 5'b11011,
            5'b11100, 5'b11101, 5'b11110: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic expectDecode(input int r1, input int r2, input logic [15:0] imm,
                                input decodeCtrl_t c);
        regRead_t expRd;
        expRd.readReg1 = 4'(r1);
        expRd.readReg2 = 4'(r2);
        assert (rd == expRd && ctrl == c && immNum == imm)
        else begin
            decodeErrors++;
            $display("FAILED %0t: instr %h gave rd %h ctrl %h imm %h, expected %h %h %h",
                     $time, instr, rd, ctrl, immNum, expRd, c, imm);
        end
    endtask

    task automatic applyInstr(input logic [15:0] ins, input int r1, input int r2,
                              input logic [15:0] imm, input decodeCtrl_t c);
        @(posedge clk);
        instr <= ins;
        @(negedge clk); // Outputs settled
        expectDecode(r1, r2, imm, c);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        decodeCtrl_t nopExpected;
        int unsigned checkerErrors;
        clk = 1'b0;
        rst = 1'b0;
        instr = '0;
        writeBackReg = `REG_ZERO;
        writeBackData = '0;
        rngState = 32'd58;
        nopExpected = ctrlOf(aluAdd, srcNone, memNone, 0, brNonZero, 0, 15);

        repeat (resetCycles) @(posedge clk);
        rst <= 1'b1;

        // ADDU sweep over R0..R7 while nothing is written
        for (int i = 0; i < 8; i++) begin
            applyInstr({5'b11100, 3'(i), 3'(7 - i), 3'b000, 2'b01}, i, 7 - i, 16'h0000,
                       ctrlOf(aluAdd, srcReg, memNone, 0, brNonZero, 0, 0));
        end

        applyInstr(16'h6BA5, 15, 15, 16'h00A5, ctrlOf(aluAdd, srcImm, memNone, 0, brNonZero, 0, 3));
        applyInstr(16'h4AFD, 2, 15, 16'hFFFD, ctrlOf(aluAdd, srcImm, memNone, 0, brNonZero, 0, 2));
        applyInstr(16'h3180, 4, 15, 16'h0008, ctrlOf(aluSll, srcImm, memNone, 0, brNonZero, 0, 1));
        applyInstr(16'h995F, 1, 15, 16'hFFFF, ctrlOf(aluAdd, srcImm, memRead, 0, brNonZero, 1, 2));
        applyInstr(16'hD610, 8, 6, 16'h0010, ctrlOf(aluAdd, srcNone, memWrite, 0, brNonZero, 0, 15));
        applyInstr(16'h17FE, 15, 15, 16'hFFFE, ctrlOf(aluAdd, srcNone, memNone, 1, brAlways, 0, 15));
        applyInstr(16'h2405, 4, 15, 16'h0005, ctrlOf(aluSub, srcNone, memNone, 1, brZero, 0, 15));
        applyInstr(16'hEF00, 7, 15, 16'h0000, ctrlOf(aluAdd, srcNone, memNone, 1, brReg, 0, 15));
        applyInstr(16'hEA6A, 2, 3, 16'h0000, ctrlOf(aluCmp, srcReg, memNone, 0, brNonZero, 0, 9));
        applyInstr(16'hEDC2, 5, 6, 16'h0000, ctrlOf(aluSlt, srcReg, memNone, 0, brNonZero, 0, 9));
        applyInstr(16'hF400, 10, 15, 16'h0000, ctrlOf(aluAdd, srcNone, memNone, 0, brNonZero, 0, 4));
        applyInstr(16'hF601, 6, 15, 16'h0000, ctrlOf(aluAdd, srcNone, memNone, 0, brNonZero, 0, 10));
        applyInstr(16'hEB40, 15, 15, 16'h0000, ctrlOf(aluPc, srcNone, memNone, 0, brNonZero, 0, 3));
        applyInstr(16'h63FC, 8, 15, 16'hFFFC, ctrlOf(aluAdd, srcImm, memNone, 0, brNonZero, 0, 8));

        // Random instructions and write-back traffic
        repeat (randomCycles) begin
            @(posedge clk);
            rngState = xorshift32(rngState);
            instr <= rngState[15:0];
            writeBackReg <= rngState[19:16];
            rngState = xorshift32(rngState);
            writeBackData <= rngState[15:0];
            @(negedge clk);
            if (!isDecodedOpcode(instr[15:11])) begin
                expectDecode(15, 15, 16'h0000, nopExpected);
            end
        end

        @(posedge clk);
        writeBackReg <= `REG_ZERO;
        repeat (2) @(posedge clk);
        @(negedge clk);
        checkerErrors = u_decodeStage.u_checker.errCount;
        $display("Errors: decode %0d, checker %0d", decodeErrors, checkerErrors);
        if (decodeErrors == 0 && checkerErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
